// ==== verilog/alu_defs.svh ====
// ----------------------------------------
// ALU word width, control field widths
// and fixed-point saturation limits
// ----------------------------------------

`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Data path width, set by the instruction encoding
`define ALU_WIDTH 16

// Sub-code field widths
`define ALU_SC1_W 3
`define ALU_SC2_W 2

// ----------------------------------------
// Fixed-point limits
// ----------------------------------------
`define ALU_MAX_POS 16'h7fff    // Largest positive value
`define ALU_MAX_NEG 16'h8000    // Most negative value

// Result for a sub-code with no operation behind it
`define ALU_DEFAULT_RES 16'h0001

`endif

// ==== verilog/alu_pkg.sv ====
// ----------------------------------------
// Shared ALU types: data word and
// operation class encoding
// ----------------------------------------

`include "alu_defs.svh"

package alu_pkg;

    // One fixed-point data word
    typedef logic [`ALU_WIDTH-1:0] alu_word_t;

    // Operation class, taken from the hc field of the instruction
    typedef enum logic [1:0]
    {
        ALU_CLASS_ADD     = 2'b00,  // Adder based ops
        ALU_CLASS_LOGIC   = 2'b01,  // Bitwise and reductions
        ALU_CLASS_COMPARE = 2'b10,  // MIN, MAX, CLIP, COMP
        ALU_CLASS_MISC    = 2'b11   // PASS, ABS
    } alu_class_t;

endpackage

// ==== verilog/alu_operand_latch.sv ====
// ----------------------------------------
// Execute-stage capture of operands and
// control on the ALU enable strobe
// ----------------------------------------

`timescale 1ns/10ps

`include "alu_defs.svh"

module alu_operand_latch
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ps_alu_en,
    input  alu_pkg::alu_word_t     xb_dtx,
    input  alu_pkg::alu_word_t     xb_dty,
    input  alu_pkg::alu_class_t    ps_alu_hc,
    input  logic [`ALU_SC1_W-1:0]  ps_alu_sc1,
    input  logic [`ALU_SC2_W-1:0]  ps_alu_sc2,
    input  logic                   ps_alu_sat,
    input  logic                   ps_alu_ci,
    output logic                   en_q,
    output alu_pkg::alu_word_t     x,
    output alu_pkg::alu_word_t     y,
    output alu_pkg::alu_class_t    op_class,
    output logic [`ALU_SC1_W-1:0]  sc1,
    output logic [`ALU_SC2_W-1:0]  sc2,
    output logic                   sat,
    output logic                   ci
);

    // Enable delayed by one edge, marks a fresh capture
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            en_q <= 1'b0;
        else
            en_q <= ps_alu_en;
    end

    // Operation registers, held while the enable is low
    // Idle values make the adder produce 16'h0001
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            x        <= `ALU_WIDTH'h0001;
            y        <= '0;
            op_class <= alu_pkg::ALU_CLASS_ADD;
            sc1      <= '0;
            sc2      <= '0;
            sat      <= 1'b0;
            ci       <= 1'b0;
        end
        else if (ps_alu_en)
        begin
            x        <= xb_dtx;
            y        <= ps_alu_sc2[1] ? '0 : xb_dty;   // Zero y on request
            op_class <= ps_alu_hc;
            sc1      <= ps_alu_sc1;
            sc2      <= ps_alu_sc2;
            sat      <= ps_alu_sat;
            ci       <= ps_alu_ci;
        end
    end

endmodule

// ==== verilog/alu_add_unit.sv ====
// ----------------------------------------
// Fixed-point adder: add, carry, subtract,
// borrow, average and saturation
// ----------------------------------------

`timescale 1ns/10ps

`include "alu_defs.svh"

module alu_add_unit
(
    input  alu_pkg::alu_word_t     x,
    input  alu_pkg::alu_word_t     y,
    input  logic [`ALU_SC1_W-1:0]  sc1,
    input  logic [`ALU_SC2_W-1:0]  sc2,
    input  logic                   sat,
    input  logic                   ci,
    output alu_pkg::alu_word_t     add_result,
    output logic                   add_carry,
    output logic                   add_ovf
);

    alu_pkg::alu_word_t   b;          // Second operand after inversion
    logic                 cin;
    logic [`ALU_WIDTH:0]  sum_full;   // Sum with carry out on top
    alu_pkg::alu_word_t   sum;
    logic                 msb_cin;    // Carry into the sign bit
    logic                 avg_sel;

    // ----------------------------------------
    // Operand and carry forming
    // ----------------------------------------
    always_comb
    begin
        if (sc2[0])
        begin
            // Subtract, borrow form uses ci in place of the +1
            b   = ~y;
            cin = sc1[0] ? ci : 1'b1;
        end
        else
        begin
            b   = y;
            cin = sc1[0] & ci;
        end
    end

    assign sum_full = {1'b0, x} + {1'b0, b} + {{`ALU_WIDTH{1'b0}}, cin};
    assign sum      = sum_full[`ALU_WIDTH-1:0];
    assign msb_cin  = x[`ALU_WIDTH-1] ^ b[`ALU_WIDTH-1] ^ sum[`ALU_WIDTH-1];

    assign avg_sel   = ~sc2[0] & sc1[1];
    assign add_carry = sum_full[`ALU_WIDTH];

    // Halving cannot overflow
    assign add_ovf = avg_sel ? 1'b0 : (msb_cin ^ sum_full[`ALU_WIDTH]);

    // ----------------------------------------
    // Result with average and saturation
    // ----------------------------------------
    always_comb
    begin
        if (sat && add_ovf)
            add_result = sum[`ALU_WIDTH-1] ? `ALU_MAX_POS : `ALU_MAX_NEG;
        else if (avg_sel)
            add_result = {sum[`ALU_WIDTH-1], sum[`ALU_WIDTH-1:1]};    // Arithmetic shift
        else
            add_result = sum;
    end

endmodule

// ==== verilog/alu_compare_unit.sv ====
// ----------------------------------------
// Signed compare: MIN, MAX, CLIP, COMP
// ----------------------------------------

`timescale 1ns/10ps

`include "alu_defs.svh"

module alu_compare_unit
(
    input  alu_pkg::alu_word_t     x,
    input  alu_pkg::alu_word_t     y,
    input  logic [`ALU_SC1_W-1:0]  sc1,
    output alu_pkg::alu_word_t     cmp_result
);

    logic                x_lt_y;
    logic                x_eq_y;
    alu_pkg::alu_word_t  mag_x;     // |x| as unsigned, 8000 stays 8000
    alu_pkg::alu_word_t  mag_y;
    alu_pkg::alu_word_t  neg_mag_y;
    alu_pkg::alu_word_t  clip_val;

    assign x_lt_y = $signed(x) < $signed(y);
    assign x_eq_y = (x == y);

    // Two's complement magnitudes for CLIP
    assign mag_x     = (x ^ {`ALU_WIDTH{x[`ALU_WIDTH-1]}}) + {{(`ALU_WIDTH-1){1'b0}}, x[`ALU_WIDTH-1]};
    assign mag_y     = (y ^ {`ALU_WIDTH{y[`ALU_WIDTH-1]}}) + {{(`ALU_WIDTH-1){1'b0}}, y[`ALU_WIDTH-1]};
    assign neg_mag_y = ~mag_y + `ALU_WIDTH'd1;

    // Limit |y| carries the sign of x
    always_comb
    begin
        if (mag_x <= mag_y)
            clip_val = x;
        else if (x[`ALU_WIDTH-1])
            clip_val = neg_mag_y;
        else
            clip_val = mag_y;
    end

    // Only the low two sub-code bits select here
    always_comb
    begin
        case (sc1[1:0])
            2'b00:   cmp_result = x_lt_y ? x : y;      // MIN
            2'b10:   cmp_result = x_lt_y ? y : x;      // MAX
            2'b01:   cmp_result = clip_val;            // CLIP
            default:
            begin
                // COMP gives 0, -1 or +1
                if (x_eq_y)
                    cmp_result = '0;
                else if (x_lt_y)
                    cmp_result = '1;
                else
                    cmp_result = `ALU_WIDTH'h0001;
            end
        endcase
    end

endmodule

// ==== verilog/alu_logic_unit.sv ====
// ----------------------------------------
// Bitwise and reduction ops, PASS and
// saturating ABS
// ----------------------------------------

`timescale 1ns/10ps

`include "alu_defs.svh"

module alu_logic_unit
(
    input  alu_pkg::alu_word_t     x,
    input  alu_pkg::alu_word_t     y,
    input  logic [`ALU_SC1_W-1:0]  sc1,
    input  logic                   sat,
    output alu_pkg::alu_word_t     logic_result,
    output alu_pkg::alu_word_t     misc_result,
    output logic                   abs_ovf
);

    alu_pkg::alu_word_t  abs_x;

    // Logic class
    always_comb
    begin
        case (sc1)
            3'b000:  logic_result = x & y;
            3'b001:  logic_result = x | y;
            3'b010:  logic_result = x ^ y;
            3'b100:  logic_result = {{(`ALU_WIDTH-1){1'b0}}, &x};   // Reduce AND
            3'b101:  logic_result = {{(`ALU_WIDTH-1){1'b0}}, |x};   // Reduce OR
            3'b111:  logic_result = ~x;
            default: logic_result = `ALU_DEFAULT_RES;
        endcase
    end

    // ----------------------------------------
    // Misc class
    // ----------------------------------------
    assign abs_x   = (x ^ {`ALU_WIDTH{x[`ALU_WIDTH-1]}}) + {{(`ALU_WIDTH-1){1'b0}}, x[`ALU_WIDTH-1]};
    assign abs_ovf = (sc1 == 3'b011) && (x == `ALU_MAX_NEG);   // -32768 has no positive

    always_comb
    begin
        case (sc1)
            3'b001:  misc_result = x;                                   // PASS
            3'b011:  misc_result = (sat && abs_ovf) ? `ALU_MAX_POS : abs_x;
            default: misc_result = `ALU_DEFAULT_RES;
        endcase
    end

endmodule

// ==== verilog/alu_result_flags.sv ====
// ----------------------------------------
// Result select, status flags and
// compare-done strobe
// ----------------------------------------

`timescale 1ns/10ps

`include "alu_defs.svh"

module alu_result_flags
(
    input  logic                   en_q,
    input  alu_pkg::alu_word_t     x,
    input  alu_pkg::alu_class_t    op_class,
    input  logic [`ALU_SC1_W-1:0]  sc1,
    input  alu_pkg::alu_word_t     add_result,
    input  logic                   add_carry,
    input  logic                   add_ovf,
    input  alu_pkg::alu_word_t     cmp_result,
    input  alu_pkg::alu_word_t     logic_result,
    input  alu_pkg::alu_word_t     misc_result,
    input  logic                   abs_ovf,
    output alu_pkg::alu_word_t     alu_xb_dt,
    output logic                   alu_ps_az,
    output logic                   alu_ps_an,
    output logic                   alu_ps_ac,
    output logic                   alu_ps_av,
    output logic                   alu_ps_as,
    output logic                   alu_ps_compd
);

    logic is_abs;

    always_comb
    begin
        case (op_class)
            alu_pkg::ALU_CLASS_ADD:     alu_xb_dt = add_result;
            alu_pkg::ALU_CLASS_LOGIC:   alu_xb_dt = logic_result;
            alu_pkg::ALU_CLASS_COMPARE: alu_xb_dt = cmp_result;
            default:                    alu_xb_dt = misc_result;
        endcase
    end

    assign is_abs = (op_class == alu_pkg::ALU_CLASS_MISC) && (sc1 == 3'b011);

    // Flags from the selected result
    assign alu_ps_az = (alu_xb_dt == '0);
    assign alu_ps_an = alu_xb_dt[`ALU_WIDTH-1];
    assign alu_ps_ac = (op_class == alu_pkg::ALU_CLASS_ADD) & add_carry;
    assign alu_ps_av = ((op_class == alu_pkg::ALU_CLASS_ADD) & add_ovf) | (is_abs & abs_ovf);
    assign alu_ps_as = is_abs & x[`ALU_WIDTH-1];   // Sign of x before ABS

    // One cycle only, right after a COMP capture
    assign alu_ps_compd = en_q && (op_class == alu_pkg::ALU_CLASS_COMPARE) && (sc1[1:0] == 2'b11);

endmodule

// ==== verilog/alu_top.sv ====
// ----------------------------------------
// ALU top: operand latch, add, compare
// and logic units, result stage
// ----------------------------------------

`timescale 1ns/10ps

`include "alu_defs.svh"

module alu_top
(
    input  logic                   clk,
    input  logic                   reset,
    input  alu_pkg::alu_word_t     xb_dtx,
    input  alu_pkg::alu_word_t     xb_dty,
    input  logic                   ps_alu_en,
    input  logic                   ps_alu_sat,
    input  logic                   ps_alu_ci,
    input  alu_pkg::alu_class_t    ps_alu_hc,
    input  logic [`ALU_SC1_W-1:0]  ps_alu_sc1,
    input  logic [`ALU_SC2_W-1:0]  ps_alu_sc2,
    output alu_pkg::alu_word_t     alu_xb_dt,
    output logic                   alu_ps_az,
    output logic                   alu_ps_an,
    output logic                   alu_ps_ac,
    output logic                   alu_ps_av,
    output logic                   alu_ps_as,
    output logic                   alu_ps_compd
);

    // Captured operation
    logic                   en_q;
    alu_pkg::alu_word_t     x;
    alu_pkg::alu_word_t     y;
    alu_pkg::alu_class_t    op_class;
    logic [`ALU_SC1_W-1:0]  sc1;
    logic [`ALU_SC2_W-1:0]  sc2;
    logic                   sat;
    logic                   ci;

    // Unit results
    alu_pkg::alu_word_t     add_result;
    logic                   add_carry;
    logic                   add_ovf;
    alu_pkg::alu_word_t     cmp_result;
    alu_pkg::alu_word_t     logic_result;
    alu_pkg::alu_word_t     misc_result;
    logic                   abs_ovf;

    alu_operand_latch u_latch
    (
        .clk(clk), .reset(reset), .ps_alu_en(ps_alu_en),
        .xb_dtx(xb_dtx), .xb_dty(xb_dty), .ps_alu_hc(ps_alu_hc),
        .ps_alu_sc1(ps_alu_sc1), .ps_alu_sc2(ps_alu_sc2),
        .ps_alu_sat(ps_alu_sat), .ps_alu_ci(ps_alu_ci),
        .en_q(en_q), .x(x), .y(y), .op_class(op_class),
        .sc1(sc1), .sc2(sc2), .sat(sat), .ci(ci)
    );

    alu_add_unit u_add
    (
        .x(x), .y(y), .sc1(sc1), .sc2(sc2), .sat(sat), .ci(ci),
        .add_result(add_result), .add_carry(add_carry), .add_ovf(add_ovf)
    );

    alu_compare_unit u_cmp
    (
        .x(x), .y(y), .sc1(sc1), .cmp_result(cmp_result)
    );

    alu_logic_unit u_logic
    (
        .x(x), .y(y), .sc1(sc1), .sat(sat),
        .logic_result(logic_result), .misc_result(misc_result), .abs_ovf(abs_ovf)
    );

    alu_result_flags u_flags
    (
        .en_q(en_q), .x(x), .op_class(op_class), .sc1(sc1),
        .add_result(add_result), .add_carry(add_carry), .add_ovf(add_ovf),
        .cmp_result(cmp_result), .logic_result(logic_result),
        .misc_result(misc_result), .abs_ovf(abs_ovf),
        .alu_xb_dt(alu_xb_dt), .alu_ps_az(alu_ps_az), .alu_ps_an(alu_ps_an),
        .alu_ps_ac(alu_ps_ac), .alu_ps_av(alu_ps_av), .alu_ps_as(alu_ps_as),
        .alu_ps_compd(alu_ps_compd)
    );

endmodule

// ==== verif/alu_checker.sv ====
// ----------------------------------------
// Concurrent checks on the ALU outputs,
// bound into alu_top
// ----------------------------------------

`timescale 1ns/10ps

`include "alu_defs.svh"

module alu_checker
(
    input logic                 clk,
    input logic                 reset,
    input logic                 ps_alu_en,
    input alu_pkg::alu_class_t  op_class,
    input logic                 sat,
    input alu_pkg::alu_word_t   alu_xb_dt,
    input logic                 alu_ps_ac,
    input logic                 alu_ps_av,
    input logic                 alu_ps_compd
);

    // Compare-done only right after a capture edge
    compd_after_en: assert property (@(posedge clk) disable iff (!reset)
        alu_ps_compd |-> $past(ps_alu_en))
        else $error("compare-done without a capture on the previous edge");

    // Carry belongs to the add class
    ac_add_only: assert property (@(posedge clk) disable iff (!reset)
        alu_ps_ac |-> (op_class == alu_pkg::ALU_CLASS_ADD))
        else $error("carry flag set outside the add class");

    sat_limits: assert property (@(posedge clk) disable iff (!reset)
        (alu_ps_av && sat) |-> (alu_xb_dt == `ALU_MAX_POS || alu_xb_dt == `ALU_MAX_NEG))
        else $error("saturated overflow result is not a limit value");

endmodule

bind alu_top alu_checker u_checker
(
    .clk(clk), .reset(reset), .ps_alu_en(ps_alu_en), .op_class(op_class), .sat(sat),
    .alu_xb_dt(alu_xb_dt), .alu_ps_ac(alu_ps_ac), .alu_ps_av(alu_ps_av),
    .alu_ps_compd(alu_ps_compd)
);

// ==== verif/alu_tb.sv ====
// ----------------------------------------
// Clock, reset, LCG and directed tests
// per ALU operation class
// ----------------------------------------

`timescale 1ns/10ps

`include "alu_defs.svh"

module alu_tb;

    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 2;
    localparam int N_PAIRS      = 20;
    localparam int OP_CYCLES    = 2;                     // Drive edge plus capture edge
    localparam int N_OPS        = 5 * N_PAIRS * 2 + 20;  // Every pair repeated with sat at worst
    localparam int TIMEOUT      = 2 * (RESET_CYCLES + OP_CYCLES * N_OPS + 3);

    localparam logic [`ALU_WIDTH-1:0] LX = 16'hf0f3;    // Logic class operands
    localparam logic [`ALU_WIDTH-1:0] LY = 16'h3c5a;

    logic                   clk = 1'b0;
    logic                   reset;
    alu_pkg::alu_word_t     xb_dtx;
    alu_pkg::alu_word_t     xb_dty;
    logic                   ps_alu_en;
    logic                   ps_alu_sat;
    logic                   ps_alu_ci;
    alu_pkg::alu_class_t    ps_alu_hc;
    logic [`ALU_SC1_W-1:0]  ps_alu_sc1;
    logic [`ALU_SC2_W-1:0]  ps_alu_sc2;
    alu_pkg::alu_word_t     alu_xb_dt;
    logic                   alu_ps_az;
    logic                   alu_ps_an;
    logic                   alu_ps_ac;
    logic                   alu_ps_av;
    logic                   alu_ps_as;
    logic                   alu_ps_compd;

    int           errors      = 0;
    int           checks      = 0;
    int           cycle_count = 0;
    logic [31:0]  lcg_state   = 32'd97;

    alu_top u_dut
    (
        .clk(clk), .reset(reset), .xb_dtx(xb_dtx), .xb_dty(xb_dty),
        .ps_alu_en(ps_alu_en), .ps_alu_sat(ps_alu_sat), .ps_alu_ci(ps_alu_ci),
        .ps_alu_hc(ps_alu_hc), .ps_alu_sc1(ps_alu_sc1), .ps_alu_sc2(ps_alu_sc2),
        .alu_xb_dt(alu_xb_dt), .alu_ps_az(alu_ps_az), .alu_ps_an(alu_ps_an),
        .alu_ps_ac(alu_ps_ac), .alu_ps_av(alu_ps_av), .alu_ps_as(alu_ps_as),
        .alu_ps_compd(alu_ps_compd)
    );

    always #10 clk = ~clk;

    // LCG returning upper bits since the low ones repeat quickly
    function automatic alu_pkg::alu_word_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    task automatic check_word(input string name, input alu_pkg::alu_word_t exp,
                              input alu_pkg::alu_word_t act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("FAIL time=%0t %s expected=%b actual=%b", $time, name, exp, act);
        end
    endtask

    // Result plus all five flags with AZ and AN taken from the result
    task automatic check_outputs(input alu_pkg::alu_word_t res, input logic ac,
                                 input logic av, input logic s_flag);
        check_word("alu_xb_dt", res, alu_xb_dt);
        check_bit("alu_ps_az", res == '0, alu_ps_az);
        check_bit("alu_ps_an", res[`ALU_WIDTH-1], alu_ps_an);
        check_bit("alu_ps_ac", ac, alu_ps_ac);
        check_bit("alu_ps_av", av, alu_ps_av);
        check_bit("alu_ps_as", s_flag, alu_ps_as);
    endtask

    // One enabled cycle that returns just after the capture edge
    task automatic run_op(input alu_pkg::alu_word_t a, input alu_pkg::alu_word_t c,
                          input alu_pkg::alu_class_t hc, input logic [`ALU_SC1_W-1:0] sc1,
                          input logic [`ALU_SC2_W-1:0] sc2, input logic sat, input logic ci);
        @(posedge clk);
        #DRIVE_DELAY;
        xb_dtx     = a;
        xb_dty     = c;
        ps_alu_hc  = hc;
        ps_alu_sc1 = sc1;
        ps_alu_sc2 = sc2;
        ps_alu_sat = sat;
        ps_alu_ci  = ci;
        ps_alu_en  = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        ps_alu_en  = 1'b0;
    endtask

    task automatic add_case(input alu_pkg::alu_word_t a, input alu_pkg::alu_word_t c,
                            input logic [`ALU_SC1_W-1:0] sc1, input logic [`ALU_SC2_W-1:0] sc2,
                            input logic ci, input logic sat, output logic ovf);
        alu_pkg::alu_word_t  yv;
        alu_pkg::alu_word_t  b;
        alu_pkg::alu_word_t  res;
        logic                carry;
        logic                cout;
        int                  u;
        int                  s;
        yv = sc2[1] ? '0 : c;
        b  = sc2[0] ? ~yv : yv;
        if (sc2[0])
            carry = sc1[0] ? ci : 1'b1;
        else
            carry = sc1[0] & ci;
        u    = int'(a) + int'(b) + int'(carry);    // Unsigned sum
        s    = int'($signed(a)) + int'($signed(b)) + int'(carry);
        cout = (u > 65535);
        ovf  = (s > 32767) || (s < -32768);
        res  = 16'(u);
        if (!sc2[0] && sc1[1])
        begin
            res = 16'(int'($signed(res)) >>> 1);    // Average
            ovf = 1'b0;
        end
        else if (sat && ovf)
            res = (s > 32767) ? `ALU_MAX_POS : `ALU_MAX_NEG;
        run_op(a, c, alu_pkg::ALU_CLASS_ADD, sc1, sc2, sat, ci);
        check_outputs(res, cout, ovf, 1'b0);
    endtask

    task automatic cmp_case(input alu_pkg::alu_word_t a, input alu_pkg::alu_word_t c,
                            input logic [1:0] op);
        int sa;
        int sc;
        int ma;
        int mc;
        int e;
        sa = int'($signed(a));
        sc = int'($signed(c));
        ma = (sa < 0) ? -sa : sa;
        mc = (sc < 0) ? -sc : sc;
        case (op)
            2'b00:   e = (sa < sc) ? sa : sc;                            // MIN
            2'b10:   e = (sa > sc) ? sa : sc;                            // MAX
            2'b01:   e = (ma <= mc) ? sa : ((sa < 0) ? -mc : mc);         // CLIP
            default: e = (sa == sc) ? 0 : ((sa < sc) ? -1 : 1);           // COMP
        endcase
        run_op(a, c, alu_pkg::ALU_CLASS_COMPARE, {1'b0, op}, 2'b00, 1'b0, 1'b0);
        check_outputs(16'(e), 1'b0, 1'b0, 1'b0);
        check_bit("alu_ps_compd", op == 2'b11, alu_ps_compd);
    endtask

    task automatic misc_case(input alu_pkg::alu_word_t a, input logic [`ALU_SC1_W-1:0] sc1,
                             input logic sat);
        alu_pkg::alu_word_t  e;
        int                  mag;
        logic                ovf;
        logic                sgn;
        mag = int'($signed(a));
        mag = (mag < 0) ? -mag : mag;
        ovf = 1'b0;
        sgn = 1'b0;
        if (sc1 == 3'b001)
            e = a;
        else if (sc1 == 3'b011)
        begin
            ovf = mag > 32767;
            sgn = a[`ALU_WIDTH-1];
            e   = (ovf && sat) ? `ALU_MAX_POS : 16'(mag);
        end
        else
            e = `ALU_DEFAULT_RES;
        run_op(a, 16'h0000, alu_pkg::ALU_CLASS_MISC, sc1, 2'b00, sat, 1'b0);
        check_outputs(e, 1'b0, ovf, sgn);
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic test_add();
        alu_pkg::alu_word_t     a;
        alu_pkg::alu_word_t     c;
        alu_pkg::alu_word_t     r;
        logic [`ALU_SC1_W-1:0]  sc1;
        logic [`ALU_SC2_W-1:0]  sc2;
        logic                   ovf;
        for (int m = 0; m < 5; m++)
        begin
            case (m)
                0:       begin sc1 = 3'b000; sc2 = 2'b00; end   // Add
                1:       begin sc1 = 3'b001; sc2 = 2'b00; end   // Add with carry
                2:       begin sc1 = 3'b000; sc2 = 2'b01; end   // Subtract
                3:       begin sc1 = 3'b001; sc2 = 2'b01; end   // Borrow subtract
                default: begin sc1 = 3'b010; sc2 = 2'b00; end   // Average
            endcase
            for (int i = 0; i < N_PAIRS; i++)
            begin
                a = next_rand();
                c = next_rand();
                r = next_rand();
                add_case(a, c, sc1, sc2, r[0], 1'b0, ovf);
                if (ovf)
                    add_case(a, c, sc1, sc2, r[0], 1'b1, ovf);
            end
        end
        add_case(16'h1234, 16'h5555, 3'b000, 2'b10, 1'b0, 1'b0, ovf);   // y zeroed
    endtask

    task automatic test_logic();
        logic [2:0] codes [7] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101, 3'b111, 3'b011};
        alu_pkg::alu_word_t exp [7];
        exp = '{LX & LY, LX | LY, LX ^ LY, (&LX) ? 16'h0001 : 16'h0000,
                (|LX) ? 16'h0001 : 16'h0000, ~LX, `ALU_DEFAULT_RES};
        for (int i = 0; i < 7; i++)
        begin
            run_op(LX, LY, alu_pkg::ALU_CLASS_LOGIC, codes[i], 2'b00, 1'b0, 1'b0);
            check_outputs(exp[i], 1'b0, 1'b0, 1'b0);
        end
    endtask

    task automatic test_hold();
        run_op(16'h4000, 16'h4000, alu_pkg::ALU_CLASS_ADD, 3'b000, 2'b00, 1'b0, 1'b0);
        check_outputs(16'h8000, 1'b0, 1'b1, 1'b0);
        repeat (3)
        begin
            xb_dtx     = next_rand();
            xb_dty     = next_rand();
            ps_alu_hc  = alu_pkg::ALU_CLASS_MISC;
            ps_alu_sc1 = 3'b011;
            ps_alu_sat = 1'b1;
            @(posedge clk);
            #DRIVE_DELAY;
            check_outputs(16'h8000, 1'b0, 1'b1, 1'b0);
        end
    endtask

    initial
    begin
        reset      = 1'b0;
        xb_dtx     = '0;
        xb_dty     = '0;
        ps_alu_en  = 1'b0;
        ps_alu_sat = 1'b0;
        ps_alu_ci  = 1'b0;
        ps_alu_hc  = alu_pkg::ALU_CLASS_ADD;
        ps_alu_sc1 = '0;
        ps_alu_sc2 = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b1;

        check_outputs(16'h0001, 1'b0, 1'b0, 1'b0);    // Idle state
        check_bit("alu_ps_compd", 1'b0, alu_ps_compd);
        test_add();
        test_logic();
        cmp_case(16'hfff0, 16'h0005, 2'b00);
        cmp_case(16'hfff0, 16'h0005, 2'b10);
        cmp_case(16'hff00, 16'h0040, 2'b01);
        cmp_case(16'h0030, 16'hff80, 2'b01);
        cmp_case(16'h0300, 16'hff80, 2'b01);
        cmp_case(16'h1234, 16'h1234, 2'b11);
        cmp_case(16'hfffb, 16'h0003, 2'b11);
        cmp_case(16'h0064, 16'hff9c, 2'b11);
        misc_case(16'h8123, 3'b001, 1'b0);
        misc_case(16'hfff6, 3'b011, 1'b0);
        misc_case(16'h8000, 3'b011, 1'b0);
        misc_case(16'h8000, 3'b011, 1'b1);
        test_hold();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // Run limit
    initial
    begin
        while (cycle_count < TIMEOUT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: tests did not finish within %0d cycles", TIMEOUT);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/alu_pkg.sv
verilog/alu_operand_latch.sv
verilog/alu_add_unit.sv
verilog/alu_compare_unit.sv
verilog/alu_logic_unit.sv
verilog/alu_result_flags.sv
verilog/alu_top.sv
verif/alu_checker.sv
verif/alu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= alu_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/10ps

SOURCES := $(shell grep -v '^+' $(FILELIST)) verilog/alu_defs.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
